//--- project.f
+incdir+hdl
hdl/rx_pkg.sv
hdl/rx_if.sv
hdl/rx_bus_regs.sv
hdl/rx_irq.sv
hdl/rx_sector_buf.sv
hdl/rx_card_seq.sv
hdl/rx01_ctrl.sv
dv/tb_rx01.sv

//--- Makefile
TOOL  := verilator
FLAGS := --binary --timing --assert -j 0
TOP   := tb_rx01
FLIST := project.f
LOG   := sim.log
PASS  := all tests passed

SRCS  := $(shell grep -v '^+' $(FLIST)) $(wildcard hdl/*.svh)
BIN   := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qx "$(PASS)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- dv/tb_rx01.sv
`timescale 1ns/1ps
`default_nettype none
`include "rx_settings.svh"

module tb_rx01;

   // 7 sector loads of ~400 cycles plus 5 card transfers, tenfold margin
   localparam int watchdog_cycles = 40000;

   logic        wb_clk_i, wb_rst_i, wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o;
   logic [1:0]  wb_adr_i, wb_sel_i;
   logic [15:0] wb_dat_i, wb_dat_o;
   logic        irq_o, iack_i;
   logic        card_req_o, card_gnt_i, card_rd_o, card_wr_o;
   logic        card_done_i, card_ack_o, card_err_i;
   logic [`RX_LBA_W-1:0]  card_lba_o, start_offset_i;
   logic [`RX_BUF_AW-1:0] card_buf_addr_i;
   logic [7:0]  card_buf_dat_i, card_buf_dat_o;
   logic        card_buf_we_i;

   logic [7:0] disk [bit [`RX_LBA_W+`RX_BUF_AW-1:0]];   // card image, key {lba, byte}
   logic [7:0] pattern [`RX_SEC_BYTES];                 // bytes expected from the buffer
   logic [7:0] image [`RX_SEC_BYTES];
   int         req_count;          // card requests seen by the card model
   int         errors;
   logic       card_fail;          // card answers with error
   logic       exp_drv, exp_write;
   logic [6:0] exp_cyl;
   logic [4:0] exp_sec;

   rx01_ctrl rx01_ctrl_inst (.*);

   initial begin
      wb_clk_i = 1'b0;
      forever #2 wb_clk_i = ~wb_clk_i;   // 4 ns
   end

   //**************************************************************************
   // reference model
   //**************************************************************************
   function automatic logic [`RX_LBA_W-1:0] block_addr(input logic [`RX_LBA_W-1:0] offset,
         input logic drv, input logic [6:0] cyl, input logic [4:0] sec);
      int chs;
      chs = int'(drv) * 4096 + int'(cyl) * 32 + int'(sec);   // drive, cylinder, sector fields
      return offset + chs[`RX_LBA_W-1:0];
   endfunction

   function automatic logic chs_legal(input logic [6:0] cyl, input logic [4:0] sec);
      return int'(cyl) <= `RX_MAX_CYL && sec != 5'd0 && int'(sec) <= `RX_MAX_SEC;
   endfunction

   function automatic logic [15:0] csr_value(input logic err, input logic drq,
                                             input logic ide, input logic done);
      logic [15:0] v;
      v     = 16'h0000;
      v[15] = err;
      v[7]  = drq;    // transfer request
      v[6]  = ide;
      v[5]  = done;
      return v;
   endfunction

   function automatic logic [15:0] status_value(input logic idle, input logic del);
      logic [15:0] v;
      v    = 16'h0000;
      v[7] = idle;    // ready
      v[6] = del;
      v[2] = 1'b1;    // init done
      return v;
   endfunction

   //**************************************************************************
   // checks and bus access
   //**************************************************************************
   task automatic abort_run(input string why);
      $display("%s", why);
      $display("tests failed");
      $fatal(1, "run aborted");
   endtask

   task automatic check(input logic [31:0] got, input logic [31:0] want, input string what);
      if (got !== want) begin
         errors++;
         $display("ERR %0t: %s is %h, expected %h", $time, what, got, want);
         $display("tests failed");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic next_cycle();
      @(posedge wb_clk_i);
      #1;   // drive and sample after the edge
   endtask

   task automatic wb_cycle(input logic we, input logic [1:0] adr, input logic [15:0] dat,
                           output logic [15:0] rdat);
      int waited;
      next_cycle();
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      wb_we_i  = we;
      wb_adr_i = adr;
      wb_sel_i = 2'b11;
      wb_dat_i = dat;
      waited   = 0;
      do begin
         next_cycle();
         waited++;
         if (waited > 4) abort_run("no Wishbone ack for a register access");
      end while (!wb_ack_o);
      rdat = wb_dat_o;   // data comes with ack
      next_cycle();      // side effects on this edge
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
   endtask

   task automatic write_reg(input logic [1:0] adr, input logic [15:0] dat);
      logic [15:0] ignored;
      wb_cycle(1'b1, adr, dat, ignored);
   endtask

   task automatic read_reg(input logic [1:0] adr, output logic [15:0] dat);
      wb_cycle(1'b0, adr, 16'h0000, dat);
   endtask

   task automatic await_done(output logic [15:0] csr);
      int polls;
      polls = 0;
      read_reg(2'b00, csr);
      while (!csr[5]) begin   // DONE
         polls++;
         if (polls > 300) abort_run("DONE never came back after a command");
         read_reg(2'b00, csr);
      end
   endtask

   task automatic await_irq(input logic level);
      int n;
      for (n = 0; n < 20 && irq_o !== level; n++) next_cycle();
      if (irq_o !== level) abort_run("irq_o did not reach the expected level");
   endtask

   //**************************************************************************
   // command sequences
   //**************************************************************************
   task automatic new_pattern();
      for (int i = 0; i < `RX_SEC_BYTES; i++) pattern[i] = 8'($urandom);
   endtask

   task automatic fill_buffer(input logic irq_on);
      logic [15:0] rd;
      write_reg(2'b00, 16'h0001);       // fill + GO
      if (irq_on) begin
         write_reg(2'b00, 16'h0040);    // IDE while DONE low
         repeat (3) next_cycle();
         check(32'(irq_o), 0, "irq_o during fill");
      end
      for (int i = 0; i < `RX_SEC_BYTES - 1; i++) write_reg(2'b10, {8'h00, pattern[i]});
      read_reg(2'b00, rd);
      check(32'(rd), 32'(csr_value(1'b0, 1'b1, irq_on, 1'b0)), "DXCSR before last byte");
      write_reg(2'b10, {8'h00, pattern[`RX_SEC_BYTES-1]});
      read_reg(2'b00, rd);
      check(32'(rd), 32'(csr_value(1'b0, 1'b0, irq_on, 1'b1)), "DXCSR after fill");
   endtask

   task automatic empty_buffer();
      logic [15:0] rd;
      write_reg(2'b00, 16'h0003);       // empty + GO
      for (int i = 0; i < `RX_SEC_BYTES; i++) begin
         read_reg(2'b10, rd);
         check(32'(rd), 32'(pattern[i]), "DXBUF byte");
      end
      read_reg(2'b00, rd);
      check(32'(rd), 32'(csr_value(1'b0, 1'b0, 1'b0, 1'b1)), "DXCSR after empty");
   endtask

   task automatic sector_cmd(input logic [2:0] code, input logic drv,
                             input logic [6:0] cyl, input logic [4:0] sec);
      int          reqs_before;
      logic        legal;
      logic [15:0] rd;
      legal       = chs_legal(cyl, sec);
      exp_drv     = drv;
      exp_cyl     = cyl;
      exp_sec     = sec;
      exp_write   = (code != 3'b011);
      reqs_before = req_count;
      write_reg(2'b00, {11'b0, drv, code, 1'b1});
      write_reg(2'b10, {11'b0, sec});   // sector first
      write_reg(2'b10, {9'b0, cyl});    // then track, go fires
      await_done(rd);
      check(32'(rd), 32'(csr_value(!legal || card_fail, 1'b0, 1'b0, 1'b1)), "DXCSR sector");
      check(req_count - reqs_before, legal ? 1 : 0, "card requests");
   endtask

   task automatic compare_image(input logic [`RX_LBA_W-1:0] lba, input logic [7:0] mark);
      for (int i = 0; i < `RX_SEC_BYTES; i++)
         check(32'(disk[{lba, 8'(i)}]), 32'(pattern[i]), "card image byte");
      check(32'(disk[{lba, 8'(`RX_MARK_ADDR)}]), 32'(mark), "deleted-data marker");
   endtask

   task automatic read_status(input logic del);
      logic [15:0] rd;
      write_reg(2'b00, 16'h000B);       // status + GO
      read_reg(2'b10, rd);
      check(32'(rd), 32'(status_value(1'b1, del)), "status word");
   endtask

   //**************************************************************************
   // card model, answers the four-phase handshake
   //**************************************************************************
   initial begin : card_model
      int unsigned gap;
      logic [7:0]  idx;
      card_gnt_i      = 1'b0;
      card_done_i     = 1'b0;
      card_err_i      = 1'b0;
      card_buf_addr_i = '0;
      card_buf_dat_i  = 8'h00;
      card_buf_we_i   = 1'b0;
      req_count       = 0;
      forever begin
         next_cycle();
         if (card_req_o) begin
            req_count++;
            check(32'(card_lba_o), 32'(block_addr(start_offset_i, exp_drv, exp_cyl, exp_sec)),
                  "card block address");
            gap = $urandom_range(1, 6);
            repeat (gap) next_cycle();
            card_gnt_i = 1'b1;
            while (!(card_rd_o || card_wr_o)) next_cycle();
            card_gnt_i = 1'b0;
            check(32'(card_wr_o), 32'(exp_write), "card transfer direction");
            for (int i = 0; i <= `RX_SEC_BYTES; i++) begin   // 128 bytes, then marker
               idx = (i == `RX_SEC_BYTES) ? 8'(`RX_MARK_ADDR) : 8'(i);
               card_buf_addr_i = idx;
               if (card_wr_o) begin
                  next_cycle();
                  disk[{card_lba_o, idx}] = card_buf_dat_o;
               end else begin
                  card_buf_dat_i = disk.exists({card_lba_o, idx}) ? disk[{card_lba_o, idx}] : 8'h00;
                  card_buf_we_i  = 1'b1;
                  next_cycle();
               end
            end
            card_buf_we_i = 1'b0;
            gap = $urandom_range(0, 8);
            repeat (gap) next_cycle();
            card_err_i  = card_fail;
            card_done_i = 1'b1;
            while (!card_ack_o) next_cycle();
            card_done_i = 1'b0;
            while (card_req_o) next_cycle();   // err sampled on release
            card_err_i = 1'b0;
         end
      end
   end

   initial begin : watchdog
      repeat (watchdog_cycles) @(posedge wb_clk_i);
      abort_run("watchdog expired, the simulation hung");
   end

   //**************************************************************************
   // test sequence
   //**************************************************************************
   initial begin : main
      logic [15:0] rd;
      void'($urandom(32'h049b_b19a));
      errors         = 0;
      wb_rst_i       = 1'b1;
      wb_cyc_i       = 1'b0;
      wb_stb_i       = 1'b0;
      wb_we_i        = 1'b0;
      wb_adr_i       = 2'b00;
      wb_sel_i       = 2'b00;
      wb_dat_i       = 16'h0000;
      iack_i         = 1'b0;
      start_offset_i = 27'h0000100;
      card_fail      = 1'b0;
      exp_drv        = 1'b0;
      exp_write      = 1'b0;
      exp_cyl        = 7'd0;
      exp_sec        = 5'd0;
      repeat (8) @(posedge wb_clk_i);
      #1 wb_rst_i = 1'b0;

      // reset state
      check(32'({wb_ack_o, card_req_o, card_rd_o, card_wr_o, card_ack_o}), 0, "outputs");
      read_reg(2'b00, rd);
      check(32'(rd), 32'(csr_value(1'b0, 1'b0, 1'b0, 1'b1)), "DXCSR after reset");
      check(32'(irq_o), 0, "irq_o after reset");

      // fill, empty, stray DXBUF read
      new_pattern();
      fill_buffer(1'b0);
      empty_buffer();
      read_reg(2'b10, rd);
      check(32'(rd), 0, "DXBUF read with DRQ low");
      read_reg(2'b00, rd);
      check(32'(rd), 32'(csr_value(1'b0, 1'b0, 1'b0, 1'b1)), "DXCSR after stray read");

      // write, deleted-data write, reads
      new_pattern();
      fill_buffer(1'b0);
      sector_cmd(3'b010, 1'b0, 7'd5, 5'd3);
      compare_image(block_addr(start_offset_i, 1'b0, 7'd5, 5'd3), 8'h00);
      new_pattern();
      fill_buffer(1'b0);
      sector_cmd(3'b110, 1'b1, 7'd40, 5'd26);
      compare_image(block_addr(start_offset_i, 1'b1, 7'd40, 5'd26), 8'h01);
      image = pattern;
      new_pattern();
      fill_buffer(1'b0);                      // overwrite buffer before the read
      sector_cmd(3'b011, 1'b1, 7'd40, 5'd26);
      pattern = image;
      empty_buffer();
      read_status(1'b1);
      sector_cmd(3'b011, 1'b0, 7'd5, 5'd3);
      read_status(1'b0);

      // range errors, command 100, card error
      sector_cmd(3'b010, 1'b0, 7'd77, 5'd1);
      sector_cmd(3'b010, 1'b0, 7'd0, 5'd0);
      sector_cmd(3'b011, 1'b0, 7'd0, 5'd27);
      write_reg(2'b00, 16'h0009);
      read_reg(2'b00, rd);
      check(32'(rd), 32'(csr_value(1'b1, 1'b0, 1'b0, 1'b1)), "DXCSR after command 100");
      card_fail = 1'b1;
      sector_cmd(3'b010, 1'b0, 7'd76, 5'd1);
      card_fail = 1'b0;

      // interrupt on completion, ack, no rearm
      new_pattern();
      fill_buffer(1'b1);
      await_irq(1'b1);
      iack_i = 1'b1;
      await_irq(1'b0);
      repeat (3) next_cycle();
      check(32'(irq_o), 0, "irq_o while iack_i held");
      iack_i = 1'b0;
      repeat (10) next_cycle();
      check(32'(irq_o), 0, "irq_o without a new completion");
      write_reg(2'b00, 16'h004B);             // status + GO + IDE
      await_irq(1'b1);
      iack_i = 1'b1;
      await_irq(1'b0);
      iack_i = 1'b0;
      write_reg(2'b00, 16'h0000);

      // soft reset in the middle of a fill
      write_reg(2'b00, 16'h0001);
      for (int i = 0; i < 10; i++) write_reg(2'b10, {8'h00, pattern[i]});
      write_reg(2'b00, 16'h4000);
      read_reg(2'b00, rd);
      check(32'(rd), 32'(csr_value(1'b0, 1'b0, 1'b0, 1'b1)), "DXCSR after soft reset");
      check(32'(irq_o), 0, "irq_o after soft reset");
      check(32'(card_req_o), 0, "card_req_o after soft reset");

      if (errors == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- hdl/rx01_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "rx_settings.svh"

module rx01_ctrl (
   input  wire                  wb_clk_i,
   input  wire                  wb_rst_i,
   // wishbone slave
   input  wire                  wb_cyc_i,
   input  wire                  wb_stb_i,
   input  wire                  wb_we_i,
   input  wire  [1:0]           wb_adr_i,
   input  wire  [1:0]           wb_sel_i,
   input  wire  [15:0]          wb_dat_i,
   output wire  [15:0]          wb_dat_o,
   output wire                  wb_ack_o,
   // interrupt
   output wire                  irq_o,
   input  wire                  iack_i,
   // block engine handshake
   output wire                  card_req_o,
   input  wire                  card_gnt_i,
   output wire                  card_rd_o,
   output wire                  card_wr_o,
   input  wire                  card_done_i,
   output wire                  card_ack_o,
   input  wire                  card_err_i,
   output wire [`RX_LBA_W-1:0]  card_lba_o,
   input  wire [`RX_LBA_W-1:0]  start_offset_i,
   // block engine side of the sector buffer
   input  wire [`RX_BUF_AW-1:0] card_buf_addr_i,
   input  wire [7:0]            card_buf_dat_i,
   input  wire                  card_buf_we_i,
   output wire [7:0]            card_buf_dat_o
);

   wire ide, done_set, go_clr, ide_set, soft_rst;
   wire mark_we, mark_val;

   rx_cmd_if cmd_if ();
   rx_buf_if buf_if ();

   rx_bus_regs rx_bus_regs_inst (
      .wb_clk_i, .wb_rst_i, .wb_cyc_i, .wb_stb_i, .wb_we_i,
      .wb_adr_i, .wb_sel_i, .wb_dat_i, .wb_dat_o, .wb_ack_o,
      .ide_o(ide), .done_set_o(done_set), .go_clr_o(go_clr),
      .ide_set_o(ide_set), .soft_rst_o(soft_rst),
      .cmd_if(cmd_if.host), .buf_if(buf_if.host)
   );

   rx_irq rx_irq_inst (
      .wb_clk_i, .wb_rst_i, .soft_rst_i(soft_rst), .ide_i(ide),
      .done_set_i(done_set), .go_clr_i(go_clr), .ide_set_i(ide_set),
      .iack_i, .irq_o
   );

   rx_sector_buf rx_sector_buf_inst (
      .wb_clk_i, .buf_if(buf_if.mem),
      .card_buf_addr_i, .card_buf_dat_i, .card_buf_we_i, .card_buf_dat_o,
      .mark_we_i(mark_we), .mark_val_i(mark_val)
   );

   // host port sits on the marker byte while DRQ is low
   rx_card_seq rx_card_seq_inst (
      .wb_clk_i, .wb_rst_i, .soft_rst_i(soft_rst), .cmd_if(cmd_if.seq),
      .start_offset_i, .card_req_o, .card_gnt_i, .card_rd_o, .card_wr_o,
      .card_done_i, .card_ack_o, .card_err_i, .card_lba_o,
      .mark_we_o(mark_we), .mark_val_o(mark_val), .mark_rd_i(buf_if.rdat[0])
   );

endmodule

`default_nettype wire

//--- hdl/rx_card_seq.sv
`timescale 1ns/1ps
`default_nettype none
`include "rx_settings.svh"

module rx_card_seq import rx_pkg::*; (
   input  wire                  wb_clk_i,
   input  wire                  wb_rst_i,
   input  wire                  soft_rst_i,
   rx_cmd_if.seq                cmd_if,
   input  wire [`RX_LBA_W-1:0]  start_offset_i,
   output logic                 card_req_o,
   input  wire                  card_gnt_i,
   output logic                 card_rd_o,
   output logic                 card_wr_o,
   input  wire                  card_done_i,
   output logic                 card_ack_o,
   input  wire                  card_err_i,
   output logic [`RX_LBA_W-1:0] card_lba_o,
   output logic                 mark_we_o,
   output logic                 mark_val_o,
   input  wire                  mark_rd_i
);

   rx_io_e state;
   logic   is_write, range_bad;
   logic   fin_q, err_q, del_q;

   assign is_write  = (cmd_if.cmd != cmd_read);   // only 010/011/110 get here
   assign range_bad = (cmd_if.cyl > 7'(`RX_MAX_CYL)) || (cmd_if.sec > 5'(`RX_MAX_SEC))
                      || (cmd_if.sec == 5'd0);

   // image offset + {drive, cylinder, sector}
   assign card_lba_o = start_offset_i
                       + {{(`RX_LBA_W-13){1'b0}}, cmd_if.drv, cmd_if.cyl, cmd_if.sec};

   // marker goes into the buffer once, before the card is asked
   assign mark_we_o  = (state == io_start) & is_write & ~range_bad & ~card_req_o;
   assign mark_val_o = (cmd_if.cmd == cmd_write_del);

   assign cmd_if.fin      = fin_q;
   assign cmd_if.err      = err_q;
   assign cmd_if.del_flag = del_q;
   assign cmd_if.busy     = (state != io_idle);

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         state <= io_idle;
         {card_req_o, card_rd_o, card_wr_o, card_ack_o} <= 4'b0000;
         {fin_q, err_q, del_q} <= 3'b000;
      end else if (soft_rst_i) begin
         state <= io_idle;
         {card_req_o, card_rd_o, card_wr_o, card_ack_o} <= 4'b0000;
         {fin_q, err_q, del_q} <= 3'b000;
      end else begin
         fin_q <= 1'b0;
         case (state)
            io_idle: if (cmd_if.go) state <= io_start;
            io_start: begin
               if (range_bad) begin   // no card access at all
                  fin_q <= 1'b1;
                  err_q <= 1'b1;
                  state <= io_idle;
               end else begin
                  card_req_o <= 1'b1;
                  if (card_req_o && card_gnt_i) begin   // granted, start transfer
                     card_rd_o <= ~is_write;
                     card_wr_o <= is_write;
                     state     <= io_wait;
                  end
               end
            end
            io_wait: if (card_done_i) begin
               card_ack_o <= 1'b1;
               state      <= io_ack;
            end
            io_ack: if (!card_done_i) begin
               card_ack_o <= 1'b0;
               state      <= io_done;
            end
            io_done: begin   // release card, report
               card_req_o <= 1'b0;
               card_rd_o  <= 1'b0;
               card_wr_o  <= 1'b0;
               fin_q      <= 1'b1;
               err_q      <= card_err_i;
               if (!is_write) del_q <= mark_rd_i;   // byte 255 from the image
               state      <= io_idle;
            end
            default: state <= io_idle;
         endcase
      end
   end

   rd_wr_excl_a: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      !(card_rd_o && card_wr_o));

endmodule

`default_nettype wire

//--- hdl/rx_sector_buf.sv
`timescale 1ns/1ps
`default_nettype none
`include "rx_settings.svh"

module rx_sector_buf (
   input  wire                  wb_clk_i,
   rx_buf_if.mem                buf_if,
   input  wire [`RX_BUF_AW-1:0] card_buf_addr_i,
   input  wire [7:0]            card_buf_dat_i,
   input  wire                  card_buf_we_i,
   output logic [7:0]           card_buf_dat_o,
   input  wire                  mark_we_i,
   input  wire                  mark_val_i
);

   localparam int unsigned depth = 1 << `RX_BUF_AW;
   localparam logic [`RX_BUF_AW-1:0] mark_addr = `RX_MARK_ADDR;

   logic [7:0] mem [depth];

   always_ff @(posedge wb_clk_i) begin
      if (buf_if.we) mem[buf_if.addr] <= buf_if.wdat;                // host fill
      if (mark_we_i) mem[mark_addr] <= {7'b0, mark_val_i};           // deleted-data mark
      if (card_buf_we_i) mem[card_buf_addr_i] <= card_buf_dat_i;     // card read data
   end

   assign buf_if.rdat    = mem[buf_if.addr];
   assign card_buf_dat_o = mem[card_buf_addr_i];

endmodule

`default_nettype wire

//--- hdl/rx_irq.sv
`timescale 1ns/1ps
`default_nettype none

module rx_irq (
   input  wire  wb_clk_i,
   input  wire  wb_rst_i,
   input  wire  soft_rst_i,
   input  wire  ide_i,
   input  wire  done_set_i,
   input  wire  go_clr_i,
   input  wire  ide_set_i,
   input  wire  iack_i,
   output logic irq_o
);

   typedef enum logic [1:0] {i_idle, i_req, i_wait} irq_st_e;

   irq_st_e state;
   logic    trig;       // interrupt trigger
   logic    trig_clr;

   assign trig_clr = go_clr_i | (state == i_req && ide_i && iack_i);

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         trig  <= 1'b1;   // done after reset, so pending
         state <= i_idle;
         irq_o <= 1'b0;
      end else if (soft_rst_i) begin
         trig  <= 1'b1;
         state <= i_idle;
         irq_o <= 1'b0;
      end else begin
         if (done_set_i || ide_set_i) trig <= 1'b1;   // set wins over clear
         else if (trig_clr) trig <= 1'b0;
         case (state)
            i_idle: if (ide_i && trig) begin
               state <= i_req;
               irq_o <= 1'b1;
            end
            i_req: if (!ide_i) begin   // IDE dropped, withdraw
               state <= i_idle;
               irq_o <= 1'b0;
            end else if (iack_i) begin
               state <= i_wait;
               irq_o <= 1'b0;
            end
            i_wait: if (!iack_i) state <= i_idle;   // rearm on iack low
            default: state <= i_idle;
         endcase
      end
   end

   irq_ide_a: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      $rose(irq_o) |-> $past(ide_i));

endmodule

`default_nettype wire

//--- hdl/rx_bus_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "rx_settings.svh"

module rx_bus_regs import rx_pkg::*; (
   input  wire         wb_clk_i,
   input  wire         wb_rst_i,
   input  wire         wb_cyc_i,
   input  wire         wb_stb_i,
   input  wire         wb_we_i,
   input  wire  [1:0]  wb_adr_i,
   input  wire  [1:0]  wb_sel_i,
   input  wire  [15:0] wb_dat_i,
   output logic [15:0] wb_dat_o,
   output logic        wb_ack_o,
   output logic        ide_o,
   output logic        done_set_o,   // completion strobe to irq
   output logic        go_clr_o,     // command accepted
   output logic        ide_set_o,    // IDE written 1 while DONE
   output logic        soft_rst_o,
   rx_cmd_if.host      cmd_if,
   rx_buf_if.host      buf_if
);

   localparam logic [`RX_BUF_AW-1:0] last_byte = `RX_SEC_BYTES - 1;
   localparam logic [`RX_BUF_AW-1:0] mark_addr = `RX_MARK_ADDR;

   logic req, reply, acc;
   logic csr_sel, buf_sel, csr_wr, buf_wr, buf_rd;
   logic accept, quick_fin, ptr_step, xfer_end, finish, sec_take, trk_take;
   rx_buf_word_u wr_word;
   rx_cmd_e new_cmd, cmd;
   logic start, done, err, drq, ide, rst_req, go_q;
   logic sec_phase, trk_phase, drv;
   logic [4:0] sec;
   logic [6:0] cyl;
   logic [`RX_BUF_AW-1:0] ptr;
   logic [15:0] csr_word, status_word, buf_word;

   //************************************************************************
   // bus cycle decode
   //************************************************************************
   assign req     = wb_cyc_i & wb_stb_i;
   assign reply   = req & ~wb_ack_o;   // ack goes out, read data latched
   assign acc     = req & wb_ack_o;    // side effects happen here
   assign csr_sel = (wb_adr_i == 2'b00);   // DXCSR
   assign buf_sel = (wb_adr_i == 2'b10);   // DXBUF
   assign csr_wr  = acc & wb_we_i & csr_sel;
   assign buf_wr  = acc & wb_we_i & buf_sel & wb_sel_i[0];
   assign buf_rd  = acc & ~wb_we_i & buf_sel;
   assign wr_word = wb_dat_i;
   assign new_cmd = rx_cmd_e'(wb_dat_i[3:1]);

   // GO only when nothing runs
   assign accept    = csr_wr & wb_sel_i[0] & wb_dat_i[0] & ~start & ~cmd_if.busy;
   assign quick_fin = accept & (new_cmd inside {cmd_bad, cmd_status, cmd_error});
   assign ptr_step  = start & drq & ((cmd == cmd_fill & buf_wr) | (cmd == cmd_empty & buf_rd));
   assign xfer_end  = ptr_step & (ptr == last_byte);
   assign sec_take  = start & sec_phase & buf_wr;
   assign trk_take  = start & trk_phase & buf_wr;
   assign finish    = quick_fin | xfer_end | cmd_if.fin;

   assign ide_o      = ide;
   assign done_set_o = finish;
   assign go_clr_o   = accept;
   assign ide_set_o  = csr_wr & wb_sel_i[0] & wb_dat_i[6] & done;
   assign soft_rst_o = rst_req;

   assign buf_if.addr = drq ? ptr : mark_addr;   // marker visible while idle
   assign buf_if.wdat = wr_word.byte_v.data;
   assign buf_if.we   = ptr_step & (cmd == cmd_fill);

   assign cmd_if.go  = go_q;
   assign cmd_if.cmd = cmd;
   assign cmd_if.cyl = cyl;
   assign cmd_if.sec = sec;
   assign cmd_if.drv = drv;

   // read words
   assign csr_word    = {err, 7'b0, drq, ide, done, 5'b0};
   assign status_word = {8'h00, ~cmd_if.busy, cmd_if.del_flag, 3'b000, 1'b1, 2'b00};

   always_comb begin
      buf_word = 16'h0000;   // error register reads zero
      if (cmd == cmd_empty && drq)
         buf_word = {8'h00, buf_if.rdat};
      else if (cmd == cmd_status)
         buf_word = status_word;
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i)
         wb_ack_o <= 1'b0;
      else
         wb_ack_o <= reply;   // single pulse per strobe
   end

   //************************************************************************
   // command state
   //************************************************************************
   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         start     <= 1'b0;
         done      <= 1'b1;   // controller comes up done
         err       <= 1'b0;
         drq       <= 1'b0;
         ide       <= 1'b0;
         sec_phase <= 1'b0;
         trk_phase <= 1'b0;
         go_q      <= 1'b0;
         rst_req   <= 1'b0;
         cmd       <= cmd_bad;
      end else if (rst_req) begin   // DXCSR bit 14
         start     <= 1'b0;
         done      <= 1'b1;
         err       <= 1'b0;
         drq       <= 1'b0;
         ide       <= 1'b0;
         sec_phase <= 1'b0;
         trk_phase <= 1'b0;
         go_q      <= 1'b0;
         rst_req   <= 1'b0;
         cmd       <= cmd_bad;
      end else begin
         go_q <= 1'b0;
         if (csr_wr && wb_sel_i[1]) rst_req <= wb_dat_i[14];
         if (csr_wr && wb_sel_i[0]) ide <= wb_dat_i[6];   // writable any time
         if (accept) begin
            cmd       <= new_cmd;
            start     <= ~quick_fin;
            done      <= quick_fin;   // status/error/bad end at once
            err       <= (new_cmd == cmd_bad);
            drq       <= ~quick_fin;  // fill, empty or sector entry
            sec_phase <= new_cmd inside {cmd_write, cmd_read, cmd_write_del};
            trk_phase <= 1'b0;
         end
         if (sec_take) begin
            sec_phase <= 1'b0;
            trk_phase <= 1'b1;
         end
         if (trk_take) begin   // track in, hand over to sequencer
            trk_phase <= 1'b0;
            drq       <= 1'b0;
            go_q      <= 1'b1;
         end
         if (xfer_end) begin   // 128th byte
            drq   <= 1'b0;
            done  <= 1'b1;
            start <= 1'b0;
         end
         if (cmd_if.fin) begin
            done  <= 1'b1;
            err   <= cmd_if.err;
            start <= 1'b0;
         end
      end
   end

   // read data, pointer and CHS words
   always_ff @(posedge wb_clk_i) begin
      if (reply && !wb_we_i)
         wb_dat_o <= csr_sel ? csr_word : (buf_sel ? buf_word : 16'h0000);
      if (accept) begin
         drv <= wb_dat_i[4];
         ptr <= '0;
      end else if (ptr_step) begin
         ptr <= ptr + 1'b1;
      end
      if (sec_take) sec <= wr_word.sec_v.sec;
      if (trk_take) cyl <= wr_word.trk_v.trk;
   end

   ack_single_a: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      wb_ack_o |=> !wb_ack_o);

   // sequencer must be free whenever a new sector command is launched
   go_idle_a: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      cmd_if.go |-> !cmd_if.busy);

endmodule

`default_nettype wire

//--- hdl/rx_if.sv
`timescale 1ns/1ps
`default_nettype none
`include "rx_settings.svh"

// command hand-off, register side to card sequencer
interface rx_cmd_if import rx_pkg::*; ();
   logic       go;          // one-cycle start strobe
   rx_cmd_e    cmd;
   logic [6:0] cyl;
   logic [4:0] sec;
   logic       drv;
   logic       fin;         // one-cycle completion strobe
   logic       err;         // valid with fin
   logic       del_flag;    // marker seen on last read
   logic       busy;

   modport host (output go, cmd, cyl, sec, drv,
                 input  fin, err, del_flag, busy);
   modport seq  (input  go, cmd, cyl, sec, drv,
                 output fin, err, del_flag, busy);
endinterface

// host side port of the sector buffer
interface rx_buf_if ();
   logic [`RX_BUF_AW-1:0] addr;
   logic [7:0]            wdat;
   logic                  we;
   logic [7:0]            rdat;    // async read of addr

   modport host (output addr, wdat, we, input rdat);
   modport mem  (input addr, wdat, we, output rdat);
endinterface

`default_nettype wire

//--- hdl/rx_pkg.sv
`default_nettype none

package rx_pkg;

   // function code, DXCSR bits 3..1
   typedef enum logic [2:0] {
      cmd_fill      = 3'b000,   // host -> buffer
      cmd_empty     = 3'b001,   // buffer -> host
      cmd_write     = 3'b010,
      cmd_read      = 3'b011,
      cmd_bad       = 3'b100,   // not implemented, flags error
      cmd_status    = 3'b101,
      cmd_write_del = 3'b110,   // write with deleted-data mark
      cmd_error     = 3'b111
   } rx_cmd_e;

   // card exchange sequencer
   typedef enum logic [2:0] {io_idle, io_start, io_wait, io_ack, io_done} rx_io_e;

   // one DXBUF write word, meaning depends on command phase
   typedef union packed {
      struct packed {logic [7:0]  hi; logic [7:0] data;} byte_v;   // fill data
      struct packed {logic [10:0] hi; logic [4:0] sec;}  sec_v;    // sector entry
      struct packed {logic [8:0]  hi; logic [6:0] trk;}  trk_v;    // track entry
   } rx_buf_word_u;

endpackage

`default_nettype wire

//--- hdl/rx_settings.svh
`ifndef RX_SETTINGS_SVH
`define RX_SETTINGS_SVH

// disk geometry, rx01 single density
`define RX_MAX_CYL     76      // last legal cylinder
`define RX_MAX_SEC     26      // last legal sector, numbering starts at 1

// sector buffer
`define RX_SEC_BYTES   128     // bytes moved per fill/empty
`define RX_BUF_AW      8       // buffer address width, 256 bytes
`define RX_MARK_ADDR   255     // deleted-data marker byte

// card side
`define RX_LBA_W       27      // card block address width

`endif
